// File: cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath sizes
`define DATA_WIDTH 16
`define ADDR_WIDTH 16
`define REG_COUNT  8

// bit positions in the 4-bit status register
`define FLAG_C 0
`define FLAG_V 1
`define FLAG_N 2
`define FLAG_Z 3

`endif

// File: isaPkg.sv
`include "cpu_defines.svh"

package isaPkg;

   typedef logic [`DATA_WIDTH-1:0] word_t;
   typedef logic [2:0]             regIndex_t;
   typedef logic [3:0]             flags_t;    // indexed by the FLAG macros

   // instruction bits 15..11
   typedef enum logic [4:0] {
      ADD    = 5'd0,
      ADDI   = 5'd1,
      SUB    = 5'd2,
      SUBI   = 5'd3,
      CMP    = 5'd4,
      CMPI   = 5'd5,
      AND    = 5'd6,
      OR     = 5'd7,
      XOR    = 5'd8,
      NOT    = 5'd9,
      LSL    = 5'd10,
      LSR    = 5'd11,
      LDW    = 5'd12,
      STW    = 5'd13,
      BRANCH = 5'd14
   } opcode_t;

   // bits 10..8 of a BRANCH instruction
   typedef enum logic [2:0] {
      BR  = 3'd0,
      BE  = 3'd1,
      BNE = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4
   } branchCond_t;

   typedef enum logic [3:0] {
      FN_A, FN_B, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOT, FN_LSL, FN_LSR
   } aluFn_t;

   typedef enum logic {OP2_REG, OP2_IMM} op2Select_t;
   typedef enum logic {IMM_SHORT, IMM_LONG} immSelect_t;   // bits 4..0 or 7..0, signed
   typedef enum logic {PC_PLUS1, PC_ALU} pcSelect_t;

endpackage

// File: busPkg.sv
`include "cpu_defines.svh"

package busPkg;

   // memory is word addressed
   typedef logic [`ADDR_WIDTH-1:0] memAddr_t;
   typedef logic [`DATA_WIDTH-1:0] busData_t;

   // owner of the outstanding request
   typedef enum logic {
      REQ_FETCH     = 1'b0,
      REQ_LOADSTORE = 1'b1
   } requester_t;

endpackage

// File: controlUnit.sv
`include "cpu_defines.svh"

module controlUnit (
   input  logic               Clock,
   input  logic               nReset,
   input  isaPkg::word_t      instr,
   input  isaPkg::flags_t     aluFlags,
   input  logic               fetchDone,
   input  logic               lsDone,
   output logic               fetchStart,
   output logic               lsStart,
   output logic               lsWrite,
   output isaPkg::aluFn_t     aluFn,
   output isaPkg::op2Select_t op2Sel,
   output isaPkg::immSelect_t immSel,
   output isaPkg::pcSelect_t  pcSel,
   output logic               regWe,
   output logic               pcWe,
   output logic               addrWe,
   output logic               loadWe
);

   import isaPkg::*;

   typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_MEMWAIT} state_t;

   state_t      state;
   opcode_t     opcode;
   branchCond_t branchCond;
   flags_t      statusReg;
   logic        booted;     // low until the first cycle out of reset
   logic        flagWe;
   logic        complete;   // instruction retires this cycle
   logic        memOp;
   logic        taken;

   assign opcode     = opcode_t'(instr[15:11]);
   assign branchCond = branchCond_t'(instr[10:8]);
   assign lsWrite    = (opcode == STW);

   always_comb begin
      case (branchCond)
         BR:      taken = 1'b1;
         BE:      taken = statusReg[`FLAG_Z];
         BNE:     taken = !statusReg[`FLAG_Z];
         BLT:     taken = statusReg[`FLAG_N] != statusReg[`FLAG_V];
         BGE:     taken = statusReg[`FLAG_N] == statusReg[`FLAG_V];
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      aluFn    = FN_A;
      op2Sel   = OP2_REG;
      immSel   = IMM_SHORT;
      pcSel    = PC_PLUS1;
      regWe    = 1'b0;
      pcWe     = 1'b0;
      addrWe   = 1'b0;
      loadWe   = 1'b0;
      flagWe   = 1'b0;
      complete = 1'b0;
      memOp    = 1'b0;
      case (state)
         S_EXECUTE: begin
            complete = 1'b1;
            pcWe     = 1'b1;
            case (opcode)
               ADD, ADDI, SUB, SUBI, AND, OR, XOR, NOT, LSL, LSR: begin
                  regWe  = 1'b1;
                  flagWe = 1'b1;
               end
               CMP, CMPI: flagWe = 1'b1;   // flags only, rd untouched
               default: ;
            endcase
            case (opcode)
               ADD, ADDI:            aluFn = FN_ADD;
               SUB, SUBI, CMP, CMPI: aluFn = FN_SUB;
               AND:                  aluFn = FN_AND;
               OR:                   aluFn = FN_OR;
               XOR:                  aluFn = FN_XOR;
               NOT:                  aluFn = FN_NOT;
               LSL:                  aluFn = FN_LSL;
               LSR:                  aluFn = FN_LSR;
               default: ;
            endcase
            case (opcode)
               ADDI, SUBI, CMPI, LSL, LSR: op2Sel = OP2_IMM;
               LDW, STW: begin             // base plus short offset into the address register
                  aluFn    = FN_ADD;
                  op2Sel   = OP2_IMM;
                  addrWe   = 1'b1;
                  memOp    = 1'b1;
                  pcWe     = 1'b0;
                  complete = 1'b0;
               end
               BRANCH: begin               // pc relative target
                  aluFn  = FN_ADD;
                  op2Sel = OP2_IMM;
                  immSel = IMM_LONG;
                  if (taken) pcSel = PC_ALU;
               end
               default: ;
            endcase
         end
         S_MEMWAIT: begin
            if (lsDone) begin
               pcWe     = 1'b1;
               complete = 1'b1;
               if (opcode == LDW) begin
                  regWe  = 1'b1;
                  loadWe = 1'b1;
               end
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state      <= S_FETCH;
         statusReg  <= '0;
         booted     <= 1'b0;
         fetchStart <= 1'b0;
         lsStart    <= 1'b0;
      end else begin
         booted     <= 1'b1;
         fetchStart <= !booted || complete;   // first fetch, then one per retired instruction
         lsStart    <= memOp;
         if (flagWe) statusReg <= aluFlags;
         case (state)
            S_FETCH:   if (fetchDone) state <= S_EXECUTE;
            S_EXECUTE: state <= memOp ? S_MEMWAIT : S_FETCH;
            S_MEMWAIT: if (lsDone) state <= S_FETCH;
            default:   state <= S_FETCH;
         endcase
      end
   end

   stateLegal: assert property (@(posedge Clock) disable iff (!nReset)
      state inside {S_FETCH, S_EXECUTE, S_MEMWAIT});

   startsExclusive: assert property (@(posedge Clock) disable iff (!nReset)
      !(fetchStart && lsStart));

endmodule

// File: executeUnit.sv
`include "cpu_defines.svh"

module executeUnit (
   input  logic               Clock,
   input  logic               nReset,
   input  isaPkg::word_t      instr,
   input  isaPkg::aluFn_t     aluFn,
   input  isaPkg::op2Select_t op2Sel,
   input  isaPkg::immSelect_t immSel,
   input  isaPkg::pcSelect_t  pcSel,
   input  logic               regWe,
   input  logic               pcWe,
   input  logic               addrWe,
   input  logic               loadWe,
   input  isaPkg::word_t      loadData,
   output isaPkg::flags_t     aluFlags,
   output busPkg::memAddr_t   pc,
   output busPkg::memAddr_t   dataAddr,
   output isaPkg::word_t      storeData
);

   import isaPkg::*;
   import busPkg::*;

   localparam int Msb       = `DATA_WIDTH - 1;
   localparam int ShiftBits = $clog2(`DATA_WIDTH);

   word_t             regFile [`REG_COUNT];
   regIndex_t         rdIdx, raIdx, rbIdx;
   word_t             imm, opA, opB, aluResult, writeData;
   logic [`DATA_WIDTH:0] sum;
   logic              carry, overflow;

   assign rdIdx = instr[10:8];
   assign raIdx = instr[7:5];
   assign rbIdx = instr[4:2];

   assign imm = (immSel == IMM_LONG) ? word_t'(signed'(instr[7:0]))
                                     : word_t'(signed'(instr[4:0]));
   assign opA = (immSel == IMM_LONG) ? word_t'(pc) : regFile[raIdx];   // long imm is pc relative
   assign opB = (op2Sel == OP2_IMM) ? imm : regFile[rbIdx];

   always_comb begin
      sum       = '0;
      carry     = 1'b0;
      overflow  = 1'b0;
      aluResult = opA;
      case (aluFn)
         FN_B:   aluResult = opB;
         FN_ADD: begin
            sum       = {1'b0, opA} + {1'b0, opB};
            aluResult = sum[Msb:0];
            carry     = sum[`DATA_WIDTH];
            overflow  = (opA[Msb] == opB[Msb]) && (aluResult[Msb] != opA[Msb]);
         end
         FN_SUB: begin
            sum       = {1'b0, opA} + {1'b0, ~opB} + 1'b1;   // carry set means no borrow
            aluResult = sum[Msb:0];
            carry     = sum[`DATA_WIDTH];
            overflow  = (opA[Msb] != opB[Msb]) && (aluResult[Msb] != opA[Msb]);
         end
         FN_AND: aluResult = opA & opB;
         FN_OR:  aluResult = opA | opB;
         FN_XOR: aluResult = opA ^ opB;
         FN_NOT: aluResult = ~opA;
         FN_LSL: aluResult = opA << opB[ShiftBits-1:0];
         FN_LSR: aluResult = opA >> opB[ShiftBits-1:0];
         default: aluResult = opA;
      endcase
   end

   always_comb begin
      aluFlags          = '0;
      aluFlags[`FLAG_Z] = (aluResult == '0);
      aluFlags[`FLAG_N] = aluResult[Msb];
      aluFlags[`FLAG_V] = overflow;
      aluFlags[`FLAG_C] = carry;
   end

   assign writeData = loadWe ? loadData : aluResult;
   assign storeData = regFile[rdIdx];   // STW data comes from rd

   always_ff @(posedge Clock) begin
      if (regWe) regFile[rdIdx] <= writeData;
      if (addrWe) dataAddr <= memAddr_t'(aluResult);
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= '0;
      end else if (pcWe) begin
         pc <= (pcSel == PC_ALU) ? memAddr_t'(aluResult) : pc + 1'b1;
      end
   end

endmodule

// File: fetchUnit.sv
module fetchUnit (
   input  logic             Clock,
   input  logic             nReset,
   input  logic             fetchStart,
   input  busPkg::memAddr_t pc,
   input  logic             fetchReqReady,
   input  logic             fetchRspValid,
   input  busPkg::busData_t fetchRspData,
   output logic             fetchReqValid,
   output logic             fetchDone,
   output busPkg::memAddr_t fetchReqAddr,
   output isaPkg::word_t    instr
);

   import isaPkg::*;
   import busPkg::*;

   memAddr_t addrQ;

   assign fetchReqAddr = addrQ;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         fetchReqValid <= 1'b0;
         fetchDone     <= 1'b0;
      end else begin
         fetchDone <= fetchRspValid;   // instr is valid together with done
         if (fetchStart) fetchReqValid <= 1'b1;
         else if (fetchReqReady) fetchReqValid <= 1'b0;
      end
   end

   // instruction register
   always_ff @(posedge Clock) begin
      if (fetchStart) addrQ <= pc;
      if (fetchRspValid) instr <= word_t'(fetchRspData);
   end

   reqHold: assert property (@(posedge Clock) disable iff (!nReset)
      fetchReqValid && !fetchReqReady |=> fetchReqValid && $stable(fetchReqAddr));

endmodule

// File: loadStoreUnit.sv
module loadStoreUnit (
   input  logic             Clock,
   input  logic             nReset,
   input  logic             lsStart,
   input  logic             lsWrite,
   input  busPkg::memAddr_t dataAddr,
   input  isaPkg::word_t    storeData,
   input  logic             lsReqReady,
   input  logic             lsRspValid,
   input  busPkg::busData_t lsRspData,
   output logic             lsReqValid,
   output logic             lsReqWrite,
   output logic             lsDone,
   output busPkg::memAddr_t lsReqAddr,
   output busPkg::busData_t lsReqData,
   output isaPkg::word_t    loadData
);

   import isaPkg::*;
   import busPkg::*;

   memAddr_t addrQ;
   busData_t dataQ;
   logic     writeQ;

   assign lsReqAddr  = addrQ;
   assign lsReqData  = dataQ;
   assign lsReqWrite = writeQ;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         lsReqValid <= 1'b0;
         lsDone     <= 1'b0;
      end else begin
         lsDone <= lsRspValid;
         if (lsStart) lsReqValid <= 1'b1;
         else if (lsReqReady) lsReqValid <= 1'b0;
      end
   end

   always_ff @(posedge Clock) begin
      if (lsStart) begin   // request fields stay put until accepted
         addrQ  <= dataAddr;
         dataQ  <= busData_t'(storeData);
         writeQ <= lsWrite;
      end
      if (lsRspValid) loadData <= word_t'(lsRspData);   // don't care after a write
   end

endmodule

// File: busArbiter.sv
module busArbiter (
   input  logic             Clock,
   input  logic             nReset,
   input  logic             fetchReqValid,
   output logic             fetchReqReady,
   input  busPkg::memAddr_t fetchReqAddr,
   output logic             fetchRspValid,
   output busPkg::busData_t fetchRspData,
   input  logic             lsReqValid,
   output logic             lsReqReady,
   input  logic             lsReqWrite,
   input  busPkg::memAddr_t lsReqAddr,
   input  busPkg::busData_t lsReqData,
   output logic             lsRspValid,
   output busPkg::busData_t lsRspData,
   output logic             memReqValid,
   input  logic             memReqReady,
   output logic             memReqWrite,
   output busPkg::memAddr_t memReqAddr,
   output busPkg::busData_t memReqData,
   input  logic             memRspValid,
   input  busPkg::busData_t memRspData
);

   import busPkg::*;

   logic       busy;    // a response is still owed
   requester_t owner;

   // load/store has fixed priority
   assign memReqValid = !busy && (lsReqValid || fetchReqValid);
   assign memReqWrite = lsReqValid && lsReqWrite;
   assign memReqAddr  = lsReqValid ? lsReqAddr : fetchReqAddr;
   assign memReqData  = lsReqData;

   assign lsReqReady    = !busy && memReqReady;
   assign fetchReqReady = !busy && memReqReady && !lsReqValid;

   assign lsRspValid    = memRspValid && (owner == REQ_LOADSTORE);
   assign fetchRspValid = memRspValid && (owner == REQ_FETCH);
   assign lsRspData     = memRspData;
   assign fetchRspData  = memRspData;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         busy  <= 1'b0;
         owner <= REQ_FETCH;
      end else if (memReqValid && memReqReady) begin
         busy  <= 1'b1;
         owner <= lsReqValid ? REQ_LOADSTORE : REQ_FETCH;
      end else if (memRspValid) begin
         busy <= 1'b0;
      end
   end

   noStrayResponse: assert property (@(posedge Clock) disable iff (!nReset)
      memRspValid |-> busy);

endmodule

// File: cpuCore.sv
module cpuCore (
   input  logic             Clock,
   input  logic             nReset,
   output logic             memReqValid,
   input  logic             memReqReady,
   output logic             memReqWrite,
   output busPkg::memAddr_t memReqAddr,
   output busPkg::busData_t memReqData,
   input  logic             memRspValid,
   input  busPkg::busData_t memRspData
);

   import isaPkg::*;
   import busPkg::*;

   word_t      instr, loadData, storeData;
   flags_t     aluFlags;
   aluFn_t     aluFn;
   op2Select_t op2Sel;
   immSelect_t immSel;
   pcSelect_t  pcSel;
   logic       regWe, pcWe, addrWe, loadWe;
   logic       fetchStart, fetchDone, lsStart, lsDone, lsWrite;
   memAddr_t   pc, dataAddr;

   logic       fetchReqValid, fetchReqReady, fetchRspValid;
   memAddr_t   fetchReqAddr;
   busData_t   fetchRspData;
   logic       lsReqValid, lsReqReady, lsReqWrite, lsRspValid;
   memAddr_t   lsReqAddr;
   busData_t   lsReqData, lsRspData;

   controlUnit controlUnit_inst (
      .Clock, .nReset, .instr, .aluFlags, .fetchDone, .lsDone,
      .fetchStart, .lsStart, .lsWrite, .aluFn, .op2Sel, .immSel, .pcSel,
      .regWe, .pcWe, .addrWe, .loadWe
   );

   executeUnit executeUnit_inst (
      .Clock, .nReset, .instr, .aluFn, .op2Sel, .immSel, .pcSel,
      .regWe, .pcWe, .addrWe, .loadWe, .loadData,
      .aluFlags, .pc, .dataAddr, .storeData
   );

   fetchUnit fetchUnit_inst (
      .Clock, .nReset, .fetchStart, .pc, .fetchReqReady, .fetchRspValid, .fetchRspData,
      .fetchReqValid, .fetchDone, .fetchReqAddr, .instr
   );

   loadStoreUnit loadStoreUnit_inst (
      .Clock, .nReset, .lsStart, .lsWrite, .dataAddr, .storeData,
      .lsReqReady, .lsRspValid, .lsRspData,
      .lsReqValid, .lsReqWrite, .lsDone, .lsReqAddr, .lsReqData, .loadData
   );

   busArbiter busArbiter_inst (
      .Clock, .nReset,
      .fetchReqValid, .fetchReqReady, .fetchReqAddr, .fetchRspValid, .fetchRspData,
      .lsReqValid, .lsReqReady, .lsReqWrite, .lsReqAddr, .lsReqData, .lsRspValid, .lsRspData,
      .memReqValid, .memReqReady, .memReqWrite, .memReqAddr, .memReqData,
      .memRspValid, .memRspData
   );

endmodule

// File: tbCpuCore.sv
`include "cpu_defines.svh"

module tbCpuCore;

   timeunit 1ns;
   timeprecision 1ps;

   import isaPkg::*;
   import busPkg::*;

   localparam int ResetCycles = 16;
   localparam int RunTimeout  = 20000;   // cycles allowed for the whole program
   localparam int DrainCycles = 50;      // quiet time after the last store

   logic     Clock;
   logic     nReset;
   logic     memReqValid;
   logic     memReqReady;
   logic     memReqWrite;
   memAddr_t memReqAddr;
   busData_t memReqData;
   logic     memRspValid;
   busData_t memRspData;

   word_t    mem [2**`ADDR_WIDTH];
   memAddr_t expAddr [$];
   word_t    expData [$];
   int       storeCount;
   logic     firstReqSeen;
   logic     holdPending;   // last edge saw valid without ready
   memAddr_t holdAddr;
   busData_t holdData;
   logic     holdWrite;
   logic     rspPending;
   int       rspDelay;
   busData_t rspData;
   logic [31:0] rngState = 32'd14;

   cpuCore cpuCore_inst (
      .Clock, .nReset, .memReqValid, .memReqReady, .memReqWrite, .memReqAddr,
      .memReqData, .memRspValid, .memRspData
   );

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stopOnError(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkAddr(input string testName, input memAddr_t expected,
                            input memAddr_t actual);
      if (actual !== expected) begin
         stopOnError($sformatf("FAILED %s: expected %h, actual %h", testName, expected, actual));
      end
   endtask

   task automatic checkData(input string testName, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         stopOnError($sformatf("FAILED %s: expected %h, actual %h", testName, expected, actual));
      end
   endtask

   task automatic loadGolden();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  kind;
      logic [15:0] addr;
      logic [15:0] data;
      for (int a = 0; a < 2**`ADDR_WIDTH; a++) begin
         mem[a] = word_t'(a) ^ 16'h5AC3;   // unloaded words differ per address
      end
      fd = $fopen("cpu_golden.txt", "r");
      if (fd == 0) begin
         stopOnError("could not open cpu_golden.txt");
      end
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%c %h %h", kind, addr, data);
         if (n == 3) begin
            case (kind)
               "P", "D": mem[addr] = data;
               "S": begin
                  expAddr.push_back(addr);
                  expData.push_back(data);
               end
               default: ;
            endcase
         end
      end
      $fclose(fd);
      if (expAddr.size() == 0) begin
         stopOnError("the golden file lists no expected stores");
      end
   endtask

   // a request that waited must come back unchanged
   task automatic watchHold();
      if (holdPending) begin
         if (memReqValid !== 1'b1) begin
            stopOnError("memReqValid dropped before the request was accepted");
         end
         checkAddr("held request address", holdAddr, memReqAddr);
         if (memReqWrite !== holdWrite) begin
            stopOnError("memReqWrite changed while the request waited");
         end
         if (holdWrite) checkData("held store data", word_t'(holdData), word_t'(memReqData));
      end
      holdPending = memReqValid && !memReqReady;
      holdAddr    = memReqAddr;
      holdData    = memReqData;
      holdWrite   = memReqWrite;
   endtask

   task automatic serveRequest();
      if (!firstReqSeen) begin
         checkAddr("first fetch address", '0, memReqAddr);
         if (memReqWrite !== 1'b0) stopOnError("the first request after reset was a write");
         firstReqSeen = 1'b1;
      end
      if (memReqWrite) begin
         if (storeCount >= expAddr.size()) begin
            stopOnError($sformatf("a store to %h came after the last expected store", memReqAddr));
         end
         checkAddr($sformatf("store %0d address", storeCount), expAddr[storeCount], memReqAddr);
         checkData($sformatf("store %0d data", storeCount), expData[storeCount],
                   word_t'(memReqData));
         storeCount++;
         mem[memReqAddr] = word_t'(memReqData);
         rspData = '0;
      end else begin
         rspData = busData_t'(mem[memReqAddr]);
      end
      rngState   = xorshift(rngState);
      rspDelay   = int'(rngState[3:2]);   // 0 to 3 extra cycles
      rspPending = 1'b1;
   endtask

   // memory model sampling on the rising edge
   always @(posedge Clock) begin
      if (nReset) begin
         watchHold();
         memRspValid <= 1'b0;
         if (memReqValid && memReqReady) begin
            serveRequest();
         end else if (rspPending && rspDelay > 0) begin
            rspDelay--;
         end
         if (rspPending && rspDelay == 0) begin
            memRspValid <= 1'b1;
            memRspData  <= rspData;
            rspPending   = 1'b0;
         end
         rngState = xorshift(rngState);
         memReqReady <= (rngState[1:0] != 2'b00);   // stalls about one cycle in four
      end
   end

   initial begin
      int cycles;
      nReset       = 1'b0;
      memReqReady  = 1'b0;
      memRspValid  = 1'b0;
      memRspData   = '0;
      storeCount   = 0;
      firstReqSeen = 1'b0;
      holdPending  = 1'b0;
      rspPending   = 1'b0;
      rspDelay     = 0;
      loadGolden();

      for (int i = 0; i < ResetCycles; i++) begin
         @(negedge Clock);
         if (memReqValid !== 1'b0) stopOnError("memReqValid was high during reset");
      end
      @(posedge Clock);
      nReset <= 1'b1;
      @(negedge Clock);
      if (memReqValid !== 1'b0) begin
         stopOnError("memReqValid was high in the cycle after reset release");
      end

      cycles = 0;
      while (storeCount < expAddr.size() && cycles < RunTimeout) begin
         @(negedge Clock);
         cycles++;
      end
      if (storeCount < expAddr.size()) begin
         stopOnError($sformatf("timeout with only %0d of %0d expected stores seen",
                               storeCount, expAddr.size()));
      end else begin
         repeat (DrainCycles) @(negedge Clock);   // any extra store fails in the model
         $display("Everything OK");
         $finish;
      end
   end

endmodule

// File: cpu_golden.txt
# columns are kind, word address and data word in hex
# kind P is a program word, D a preloaded data word, S an expected store in order
P 0000 500F
P 0001 5001
P 0002 0F08
P 0003 57E3
P 0004 56E1
P 0005 61E0
P 0006 62E1
P 0007 63E2
P 0008 0DE4
P 0009 64BF
P 000A 6CC0
P 000B 0528
P 000C 6DC1
P 000D 1528
P 000E 6DC2
P 000F 3528
P 0010 6DC3
P 0011 3D28
P 0012 6DC4
P 0013 4528
P 0014 6DC5
P 0015 4D20
P 0016 6DC6
P 0017 0D3D
P 0018 6DC7
P 0019 1D30
P 001A 6DC8
P 001B 5524
P 001C 6DC9
P 001D 5D45
P 001E 6DCA
P 001F 6BDF
P 0020 2024
P 0021 7102
P 0022 69CB
P 0023 6ACC
P 0024 7202
P 0025 69CD
P 0026 2070
P 0027 7302
P 0028 6BCE
P 0029 7402
P 002A 6CCF
P 002B 2883
P 002C 7302
P 002D 6CCF
P 002E 7202
P 002F 69E0
P 0030 7002
P 0031 6AE1
P 0032 0D03
P 0033 1DA1
P 0034 6DE8
P 0035 72FE
P 0036 69CF
P 0037 7000
D 0040 1234
D 0041 F00F
D 0042 7FFF
D 0043 8001
S 0080 8001
S 0081 0243
S 0082 2225
S 0083 1004
S 0084 F23F
S 0085 E23B
S 0086 EDCB
S 0087 1231
S 0088 1244
S 0089 2340
S 008A 0780
S 007F 7FFF
S 008C F00F
S 008D 1234
S 008E 7FFF
S 0048 0002
S 0048 0001
S 0048 0000
S 008F 1234

// File: verilog.f
+incdir+.
isaPkg.sv
busPkg.sv
controlUnit.sv
executeUnit.sv
fetchUnit.sv
loadStoreUnit.sv
busArbiter.sv
cpuCore.sv
tbCpuCore.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - isaPkg.sv
      - busPkg.sv
      - controlUnit.sv
      - executeUnit.sv
      - fetchUnit.sv
      - loadStoreUnit.sv
      - busArbiter.sv
      - cpuCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbCpuCore.sv
